// File: verilog/axi_read_pkg.sv
package axi_read_pkg;

   localparam int axi_addr_w = 32;
   localparam int axi_data_w = 32;
   localparam int offset_w   = $clog2(axi_data_w / 8);

   // Bytes per beat as an AXI size code
   localparam logic [2:0] axi_size_c = 3'($clog2(axi_data_w / 8));

   localparam logic [1:0] axi_burst_incr_c = 2'b01;
   localparam logic [3:0] axi_cache_c      = 4'b0010;  // Modifiable, non-bufferable
   localparam logic [2:0] axi_prot_c       = 3'b010;   // Unprivileged, non-secure, data

   // Address-read channel payload
   typedef struct packed {
      logic [axi_addr_w-1:0] addr;
      logic [7:0]            len;
      logic [2:0]            size;
      logic [1:0]            burst;
      logic [3:0]            id;
      logic [3:0]            cache;
      logic [2:0]            prot;
      logic [3:0]            qos;
      logic                  lock;
   } axi_ar_t;

   // Read-data channel payload
   typedef struct packed {
      logic [axi_data_w-1:0] data;
      logic [1:0]            resp;
      logic [3:0]            id;
      logic                  last;
   } axi_r_t;

   typedef enum logic [1:0] {
      rd_idle,
      rd_plan,
      rd_addr,
      rd_data
   } read_state_e;

endpackage

// File: verilog/transfer_controller.sv
`timescale 1ns/1ns

module transfer_controller import axi_read_pkg::*; #(
   parameter int LEN_W         = 12,
   parameter int MAX_BURST_LEN = 16
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic [axi_addr_w-1:0] address_i,
   input  logic [LEN_W-1:0]      length_i,    // In bytes
   input  logic                  transfer_start_i,
   input  logic                  burst_start_i,
   output logic [axi_addr_w-1:0] burst_addr_o,
   output logic [7:0]            burst_len_o,
   output logic                  last_burst_o
);

   // Beats needed for the whole span, offset included
   localparam int beats_w = LEN_W + 1 - offset_w;

   // Beats in one 4 KB page, plus one bit to hold the full count
   localparam int page_w = 12 - offset_w + 1;

   localparam int cnt_w = (beats_w > page_w) ? beats_w : page_w;

   logic [axi_addr_w-1:0] addr_q;
   logic [beats_w-1:0]    remaining_q;
   logic                  last_burst_q;

   logic [LEN_W:0]   span;
   logic [cnt_w-1:0] remaining_ext;
   logic [cnt_w-1:0] max_ext;
   logic [cnt_w-1:0] to_page;
   logic [cnt_w-1:0] capped;
   logic [cnt_w-1:0] burst_beats;
   logic             covers_all;

   // Offset plus length, rounded up to whole beats
   assign span = {1'b0, length_i}
               + (LEN_W + 1)'(address_i[offset_w-1:0])
               + (LEN_W + 1)'(axi_data_w / 8 - 1);

   assign remaining_ext = cnt_w'(remaining_q);
   assign max_ext       = cnt_w'(MAX_BURST_LEN);

   // Beats left before the next 4 KB boundary
   assign to_page = cnt_w'(1 << (12 - offset_w)) - cnt_w'(addr_q[11:offset_w]);

   always_comb begin
      capped = (remaining_ext < max_ext) ? remaining_ext : max_ext;
      burst_beats = (capped < to_page) ? capped : to_page;
   end

   assign covers_all = (burst_beats == remaining_ext);

   assign burst_addr_o = addr_q;
   assign burst_len_o  = 8'(burst_beats - cnt_w'(1));
   assign last_burst_o = last_burst_q;

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         remaining_q  <= '0;
         last_burst_q <= 1'b0;
      end else if (transfer_start_i) begin
         remaining_q  <= span[LEN_W:offset_w];
         last_burst_q <= 1'b0;
      end else if (burst_start_i) begin
         remaining_q  <= remaining_q - beats_w'(burst_beats);
         last_burst_q <= covers_all;  // Held for the burst in flight
      end
   end

   // Word-aligned address of the next burst
   always_ff @(posedge clk_i) begin
      if (transfer_start_i) begin
         addr_q <= {address_i[axi_addr_w-1:offset_w], {offset_w{1'b0}}};
      end else if (burst_start_i) begin
         addr_q <= addr_q + axi_addr_w'({burst_beats, {offset_w{1'b0}}});
      end
   end

endmodule

// File: verilog/burst_align.sv
`timescale 1ns/1ns

module burst_align import axi_read_pkg::*; #(
   parameter int LEN_W = 12
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  start_i,
   input  logic [offset_w-1:0]   offset_i,
   input  logic [LEN_W-1:0]      length_i,
   input  logic                  beat_i,
   input  logic [axi_data_w-1:0] beat_data_i,
   input  logic                  burst_last_i,
   input  logic                  last_burst_i,
   output logic [axi_data_w-1:0] data_o,
   output logic                  valid_o,
   output logic                  last_o,
   output logic                  empty_o
);

   localparam int words_w = LEN_W + 1 - offset_w;

   logic [offset_w-1:0]   off_q;
   logic [words_w-1:0]    words_q;     // Output words still owed
   logic                  held_ok_q;
   logic                  flush_q;
   logic                  valid_q;
   logic                  last_q;
   logic                  empty_q;
   logic [axi_data_w-1:0] held_q;
   logic [axi_data_w-1:0] data_q;

   logic [LEN_W:0]        len_round;
   logic [offset_w+2:0]   lo_shift;
   logic [offset_w+2:0]   hi_shift;
   logic [axi_data_w-1:0] joined;
   logic [axi_data_w-1:0] emit_word;
   logic                  emit;
   logic                  final_beat;
   logic [words_w-1:0]    words_after;

   assign len_round = {1'b0, length_i} + (LEN_W + 1)'(axi_data_w / 8 - 1);

   assign lo_shift = {off_q, 3'b000};
   assign hi_shift = -lo_shift;  // Only meaningful for a non-zero offset

   // Upper bytes of the held beat, lower bytes of the new one
   assign joined    = (held_q >> lo_shift) | (beat_data_i << hi_shift);
   assign emit_word = (off_q == '0) ? beat_data_i : joined;

   assign emit        = beat_i && (off_q == '0 || held_ok_q) && (words_q != '0);
   assign final_beat  = beat_i && burst_last_i && last_burst_i;
   assign words_after = emit ? words_q - words_w'(1) : words_q;

   assign data_o  = data_q;
   assign valid_o = valid_q;
   assign last_o  = last_q;
   assign empty_o = empty_q;

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         off_q     <= '0;
         words_q   <= '0;
         held_ok_q <= 1'b0;
         flush_q   <= 1'b0;
         valid_q   <= 1'b0;
         last_q    <= 1'b0;
         empty_q   <= 1'b1;
      end else if (start_i) begin
         off_q     <= offset_i;
         words_q   <= len_round[LEN_W:offset_w];
         held_ok_q <= 1'b0;
         flush_q   <= 1'b0;
         valid_q   <= 1'b0;
         last_q    <= 1'b0;
         empty_q   <= 1'b0;
      end else begin
         valid_q <= 1'b0;
         last_q  <= 1'b0;
         if (last_q)
            empty_q <= 1'b1;
         if (beat_i)
            held_ok_q <= 1'b1;
         if (emit) begin
            valid_q <= 1'b1;
            last_q  <= (words_q == words_w'(1));
            words_q <= words_q - words_w'(1);
         end
         // One word left over after the final beat
         flush_q <= final_beat && (words_after != '0);
         if (flush_q) begin
            valid_q <= 1'b1;
            last_q  <= (words_q == words_w'(1));
            words_q <= words_q - words_w'(1);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (beat_i)
         held_q <= beat_data_i;
      if (emit)
         data_q <= emit_word;
      else if (flush_q)
         data_q <= held_q >> lo_shift;  // Tail bytes of the final beat
   end

endmodule

// File: verilog/simple_axi_read.sv
`timescale 1ns/1ns

module simple_axi_read import axi_read_pkg::*; #(
   parameter int LEN_W         = 12,
   parameter int MAX_BURST_LEN = 16
) (
   input  logic                  clk_i,
   input  logic                  rst_i,

   // Simple requester side
   input  logic                  m_rvalid_i,
   input  logic [axi_addr_w-1:0] m_raddr_i,
   input  logic [LEN_W-1:0]      m_rlen_i,
   output logic                  m_rready_o,
   output logic [axi_data_w-1:0] m_rdata_o,
   output logic                  m_rlast_o,

   // AXI read channels
   output axi_ar_t               axi_ar_o,
   output logic                  axi_arvalid_o,
   input  logic                  axi_arready_i,
   input  axi_r_t                axi_r_i,
   input  logic                  axi_rvalid_i,
   output logic                  axi_rready_o
);

   read_state_e state_q;

   logic       arvalid_q;
   logic [7:0] arlen_q;

   logic                  transfer_start;
   logic                  align_start;
   logic                  burst_start;
   logic                  align_empty;
   logic [axi_addr_w-1:0] burst_addr;
   logic [7:0]            burst_len;
   logic                  last_burst;
   logic                  beat;
   logic                  beat_last;

   assign transfer_start = (state_q == rd_idle) && m_rvalid_i && align_empty;
   assign align_start    = transfer_start;
   assign burst_start    = (state_q == rd_addr) && arvalid_q && axi_arready_i;

   assign axi_rready_o = (state_q == rd_data);
   assign beat         = axi_rvalid_i && axi_rready_o;
   assign beat_last    = beat && axi_r_i.last;

   assign axi_arvalid_o = arvalid_q;

   always_comb begin
      axi_ar_o       = '0;  // id, qos and lock stay zero
      axi_ar_o.addr  = burst_addr;
      axi_ar_o.len   = arlen_q;
      axi_ar_o.size  = axi_size_c;
      axi_ar_o.burst = axi_burst_incr_c;
      axi_ar_o.cache = axi_cache_c;
      axi_ar_o.prot  = axi_prot_c;
   end

   transfer_controller #(
      .LEN_W         (LEN_W),
      .MAX_BURST_LEN (MAX_BURST_LEN)
   ) read_controller (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .address_i        (m_raddr_i),
      .length_i         (m_rlen_i),
      .transfer_start_i (transfer_start),
      .burst_start_i    (burst_start),
      .burst_addr_o     (burst_addr),
      .burst_len_o      (burst_len),
      .last_burst_o     (last_burst)
   );

   burst_align #(
      .LEN_W (LEN_W)
   ) aligner (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (align_start),
      .offset_i     (m_raddr_i[offset_w-1:0]),
      .length_i     (m_rlen_i),
      .beat_i       (beat),
      .beat_data_i  (axi_r_i.data),
      .burst_last_i (beat_last),
      .last_burst_i (last_burst),
      .data_o       (m_rdata_o),
      .valid_o      (m_rready_o),
      .last_o       (m_rlast_o),
      .empty_o      (align_empty)
   );

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         state_q   <= rd_idle;
         arvalid_q <= 1'b0;
         arlen_q   <= '0;
      end else begin
         case (state_q)
            rd_idle: begin
               // Wait for the previous transfer to drain out
               if (transfer_start)
                  state_q <= rd_plan;
            end
            rd_plan: begin
               arlen_q   <= burst_len;
               arvalid_q <= 1'b1;
               state_q   <= rd_addr;
            end
            rd_addr: begin
               if (burst_start) begin
                  arvalid_q <= 1'b0;
                  state_q   <= rd_data;
               end
            end
            rd_data: begin
               if (beat_last)
                  state_q <= last_burst ? rd_idle : rd_plan;
            end
            default: state_q <= rd_idle;
         endcase
      end
   end

endmodule

// File: sim/axi_mem_model.sv
`timescale 1ns/1ns

module axi_mem_model import axi_read_pkg::*; #(
   parameter int LOG_DEPTH = 4096
) (
   input  logic    clk_i,
   input  logic    rst_i,
   input  axi_ar_t axi_ar_i,
   input  logic    axi_arvalid_i,
   output logic    axi_arready_o,
   output axi_r_t  axi_r_o,
   output logic    axi_rvalid_o,
   input  logic    axi_rready_i
);

   localparam int mem_bytes = 65536;  // Low 16 address bits only

   logic [7:0] mem [0:mem_bytes-1];

   // Accepted bursts, in order
   logic [axi_addr_w-1:0] log_addr [0:LOG_DEPTH-1];
   logic [7:0]            log_len  [0:LOG_DEPTH-1];
   int                    log_count = 0;

   logic                  arready_q  = 1'b0;
   logic                  rvalid_q   = 1'b0;
   axi_r_t                r_q        = '0;
   logic                  ar_fire    = 1'b0;
   logic                  r_fire     = 1'b0;
   axi_ar_t               ar_q       = '0;
   logic                  busy       = 1'b0;
   logic [axi_addr_w-1:0] beat_addr  = '0;
   int                    beats_left = 0;

   assign axi_arready_o = arready_q;
   assign axi_rvalid_o  = rvalid_q;
   assign axi_r_o       = r_q;

   // Byte value from its address
   function automatic logic [7:0] fill_byte(input logic [31:0] a);
      logic [7:0] lo;
      logic [7:0] hi;
      lo = a[7:0];
      hi = a[15:8];
      return lo ^ (hi * 8'd37) ^ 8'h6c;
   endfunction

   function automatic logic [31:0] read_word(input logic [axi_addr_w-1:0] a);
      logic [15:0] base;
      base = {a[15:2], 2'b00};
      return {mem[base + 16'd3], mem[base + 16'd2], mem[base + 16'd1], mem[base]};
   endfunction

   initial begin
      for (int a = 0; a < mem_bytes; a++)
         mem[a] = fill_byte(32'(a));
   end

   // Handshakes as seen on the rising edge
   always @(posedge clk_i) begin
      ar_fire <= axi_arvalid_i && arready_q;
      r_fire  <= rvalid_q && axi_rready_i;
      if (axi_arvalid_i && arready_q) begin
         ar_q                <= axi_ar_i;
         log_addr[log_count] <= axi_ar_i.addr;
         log_len[log_count]  <= axi_ar_i.len;
         log_count           <= log_count + 1;
      end
   end

   // Outputs change on the falling edge
   always @(negedge clk_i) begin
      if (rst_i) begin
         arready_q  = 1'b0;
         rvalid_q   = 1'b0;
         busy       = 1'b0;
         beats_left = 0;
      end else begin
         if (ar_fire) begin
            busy       = 1'b1;
            beat_addr  = ar_q.addr;
            beats_left = int'(ar_q.len) + 1;
         end
         if (r_fire) begin
            rvalid_q   = 1'b0;
            beat_addr  = beat_addr + 32'd4;
            beats_left = beats_left - 1;
            if (beats_left == 0)
               busy = 1'b0;
         end
         arready_q = !busy && ($urandom_range(1, 0) == 0);  // About half the cycles
         if (busy && !rvalid_q && ($urandom_range(3, 0) != 0)) begin
            rvalid_q   = 1'b1;
            r_q.data   = read_word(beat_addr);
            r_q.resp   = 2'b00;
            r_q.id     = 4'd0;
            r_q.last   = (beats_left == 1);
         end
      end
   end

endmodule

// File: sim/tb_simple_axi_read.sv
`timescale 1ns/1ns

module tb_simple_axi_read import axi_read_pkg::*; ();

   localparam int len_w         = 12;
   localparam int max_burst_len = 16;
   localparam int n_random      = 200;

   logic             clk      = 1'b0;
   logic             rst      = 1'b1;
   logic             m_rvalid = 1'b0;
   logic [31:0]      m_raddr  = '0;
   logic [len_w-1:0] m_rlen   = '0;
   logic             m_rready;
   logic [31:0]      m_rdata;
   logic             m_rlast;
   axi_ar_t          axi_ar;
   logic             axi_arvalid;
   logic             axi_arready;
   axi_r_t           axi_r;
   logic             axi_rvalid;
   logic             axi_rready;

   string       req_name [$];
   logic [31:0] req_addr [$];
   int          req_len  [$];

   // Transfer in progress
   string       cur_name    = "after_reset";
   logic [31:0] cur_addr    = '0;
   int          cur_len     = 0;
   int          word_idx    = 0;
   int          cycles      = 0;
   int          cycle_limit = 0;

   always #10 clk = ~clk;

   simple_axi_read #(
      .LEN_W         (len_w),
      .MAX_BURST_LEN (max_burst_len)
   ) dut0 (
      .clk_i         (clk),
      .rst_i         (rst),
      .m_rvalid_i    (m_rvalid),
      .m_raddr_i     (m_raddr),
      .m_rlen_i      (m_rlen),
      .m_rready_o    (m_rready),
      .m_rdata_o     (m_rdata),
      .m_rlast_o     (m_rlast),
      .axi_ar_o      (axi_ar),
      .axi_arvalid_o (axi_arvalid),
      .axi_arready_i (axi_arready),
      .axi_r_i       (axi_r),
      .axi_rvalid_i  (axi_rvalid),
      .axi_rready_o  (axi_rready)
   );

   axi_mem_model mem0 (
      .clk_i         (clk),
      .rst_i         (rst),
      .axi_ar_i      (axi_ar),
      .axi_arvalid_i (axi_arvalid),
      .axi_arready_o (axi_arready),
      .axi_r_o       (axi_r),
      .axi_rvalid_o  (axi_rvalid),
      .axi_rready_i  (axi_rready)
   );

   function automatic logic [7:0] pattern_byte(input logic [31:0] a);
      logic [7:0] lo;
      logic [7:0] hi;
      lo = a[7:0];
      hi = a[15:8];
      return lo ^ (hi * 8'd37) ^ 8'h6c;
   endfunction

   // Output word k of a request starting at addr
   function automatic logic [31:0] ref_word(input logic [31:0] addr, input int k);
      logic [31:0] w;
      for (int i = 0; i < 4; i++)
         w[i*8 +: 8] = pattern_byte(addr + 32'(k * 4 + i));
      return w;
   endfunction

   function automatic int words_for(input int len);
      return (len + 3) / 4;
   endfunction

   function automatic void add_request(input string name, input logic [31:0] addr, input int len);
      req_name.push_back(name);
      req_addr.push_back(addr);
      req_len.push_back(len);
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("** Error %s: expected %h, actual %h", what, expected, actual);
         $display("*** FAILED ***");
         $fatal(1, "value mismatch in %s", what);
      end
   endtask

   always @(negedge clk) begin
      int          nwords;
      int          valid_bytes;
      logic [31:0] mask;
      if (!rst && m_rready) begin
         nwords = words_for(cur_len);
         if (word_idx >= nwords)
            check_value({cur_name, " word count"}, 32'(nwords), 32'(word_idx + 1));
         valid_bytes = cur_len - word_idx * 4;
         mask = (valid_bytes >= 4) ? 32'hffff_ffff : (32'd1 << (valid_bytes * 8)) - 32'd1;
         check_value($sformatf("%s word %0d", cur_name, word_idx),
                     ref_word(cur_addr, word_idx) & mask, m_rdata & mask);
         check_value($sformatf("%s m_rlast_o at word %0d", cur_name, word_idx),
                     32'(word_idx == nwords - 1), 32'(m_rlast));
         word_idx = m_rlast ? 0 : word_idx + 1;
      end else if (!rst && m_rlast) begin
         check_value({cur_name, " m_rready_o with m_rlast_o"}, 32'd1, 32'(m_rready));
      end
   end

   // Fixed AR fields of a 4-byte incrementing read
   always @(negedge clk) begin
      if (!rst && axi_arvalid)
         check_value({cur_name, " AR fixed fields"},
                     32'({3'b010, 2'b01, 4'h0, 4'b0010, 3'b010, 4'h0, 1'b0}),
                     32'({axi_ar.size, axi_ar.burst, axi_ar.id, axi_ar.cache,
                          axi_ar.prot, axi_ar.qos, axi_ar.lock}));
   end

   // Bursts logged by the memory against the splitting rule
   task automatic check_bursts(input string name, input logic [31:0] addr, input int len,
                               input int first);
      logic [31:0] baddr;
      logic [31:0] last_byte;
      int          remaining;
      int          n;
      int          idx;
      for (int i = first; i < mem0.log_count; i++) begin
         last_byte = mem0.log_addr[i] + 32'((int'(mem0.log_len[i]) + 1) * 4) - 32'd1;
         check_value({name, " burst length limit"}, 32'd1,
                     32'(int'(mem0.log_len[i]) < max_burst_len));
         check_value({name, " 4 KB page"}, 32'(mem0.log_addr[i][31:12]), 32'(last_byte[31:12]));
      end
      baddr     = {addr[31:2], 2'b00};
      remaining = (int'(addr[1:0]) + len + 3) / 4;
      idx       = first;
      while (remaining > 0) begin
         n = (remaining < max_burst_len) ? remaining : max_burst_len;
         if ((4096 - int'(baddr[11:0])) / 4 < n)
            n = (4096 - int'(baddr[11:0])) / 4;
         check_value($sformatf("%s burst %0d seen", name, idx - first), 32'd1,
                     32'(idx < mem0.log_count));
         check_value($sformatf("%s burst %0d addr", name, idx - first), baddr,
                     mem0.log_addr[idx]);
         check_value($sformatf("%s burst %0d len", name, idx - first), 32'(n - 1),
                     32'(mem0.log_len[idx]));
         baddr     = baddr + 32'(n * 4);
         remaining = remaining - n;
         idx++;
      end
      check_value({name, " burst count"}, 32'(idx - first), 32'(mem0.log_count - first));
   endtask

   task automatic run_request(input string name, input logic [31:0] addr, input int len);
      int first;
      @(negedge clk);
      cur_name = name;
      cur_addr = addr;
      cur_len  = len;
      first    = mem0.log_count;
      m_raddr  = addr;
      m_rlen   = len_w'(len);
      m_rvalid = 1'b1;
      do
         @(negedge clk);
      while (!m_rlast);
      m_rvalid = 1'b0;  // Same falling edge as the last word
      check_bursts(name, addr, len, first);
   endtask

   task automatic check_idle(input int n);
      repeat (n) begin
         @(negedge clk);
         check_value("after_reset idle outputs", 32'd0,
                     32'({axi_arvalid, axi_rready, m_rready, m_rlast}));
      end
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("Timeout: transfer %s still running after %0d cycles", cur_name, cycles);
         $display("*** FAILED ***");
         $fatal(1, "simulation timed out");
      end
   end

   initial begin
      int          len;
      logic [31:0] addr;
      void'($urandom(32'hd138_3db2));
      add_request("aligned_len4", 32'h0000_0100, 4);
      add_request("aligned_len8", 32'h0000_0204, 8);
      add_request("aligned_len60", 32'h0000_1000, 60);
      add_request("off1_len3", 32'h0000_0301, 3);
      add_request("off1_len4", 32'h0000_0401, 4);
      add_request("off2_len2", 32'h0000_0502, 2);
      add_request("off3_len5", 32'h0000_0603, 5);
      add_request("off3_len9", 32'h0000_0707, 9);
      add_request("off2_len30", 32'h0000_0812, 30);
      add_request("off1_len61", 32'h0000_0921, 61);
      add_request("long_len200", 32'h0000_2000, 200);
      add_request("page_edge_len40", 32'h0000_0ff6, 40);
      add_request("page_edge_len300", 32'h0000_1fc3, 300);
      for (int i = 0; i < n_random; i++) begin
         len  = int'($urandom_range(300, 1));
         addr = $urandom_range(65536 - len, 0);
         add_request($sformatf("random_%0d", i), addr, len);
      end
      cycle_limit = 20;  // Reset and idle window
      foreach (req_len[i])
         cycle_limit += 8 * words_for(req_len[i]) + 50;

      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_idle(10);
      foreach (req_name[i])
         run_request(req_name[i], req_addr[i], req_len[i]);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: filelist.f
verilog/axi_read_pkg.sv
verilog/transfer_controller.sv
verilog/burst_align.sv
verilog/simple_axi_read.sv
sim/axi_mem_model.sv
sim/tb_simple_axi_read.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_simple_axi_read
FILELIST  := filelist.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
